/* design/branch_predictor.sv */
`timescale 1ns/1ns
`default_nettype none

module branch_predictor (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  rv_isa_pkg::xlen_t    pc_i,
    input  logic                 advance_i,
    input  logic                 is_branch_i,
    input  logic                 is_jal_i,
    input  logic                 is_jalr_i,
    input  rv_isa_pkg::reg_idx_t rs1_i,
    input  rv_isa_pkg::reg_idx_t rd_i,
    input  rv_isa_pkg::xlen_t    link_addr_i,
    input  logic                 resolve_valid_i,
    input  rv_isa_pkg::xlen_t    resolve_pc_i,
    input  logic                 resolve_taken_i,
    output logic                 bht_taken_o,
    output logic                 ras_hit_o,
    output rv_isa_pkg::xlen_t    ras_target_o
);

    ////////////////////////////////////////////////////////////////////
    // branch history table
    ////////////////////////////////////////////////////////////////////

    logic [1:0]          bht_q [fetch_pkg::bht_entries];
    fetch_pkg::bht_idx_t lookup_idx;
    fetch_pkg::bht_idx_t resolve_idx;

    assign lookup_idx  = pc_i[5:2];
    assign resolve_idx = resolve_pc_i[5:2];

    // msb set means counter is 2 or 3
    assign bht_taken_o = is_branch_i && bht_q[lookup_idx][1];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < fetch_pkg::bht_entries; i++) begin
                bht_q[i] <= 2'd1;
            end
        end else if (resolve_valid_i) begin
            if (resolve_taken_i && bht_q[resolve_idx] != 2'd3) begin
                bht_q[resolve_idx] <= bht_q[resolve_idx] + 2'd1;
            end else if (!resolve_taken_i && bht_q[resolve_idx] != 2'd0) begin
                bht_q[resolve_idx] <= bht_q[resolve_idx] - 2'd1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // return address stack
    ////////////////////////////////////////////////////////////////////

    rv_isa_pkg::xlen_t ras_q [fetch_pkg::ras_depth];
    fetch_pkg::ras_ptr_t ras_top_q;
    logic [$bits(fetch_pkg::ras_ptr_t):0] ras_count_q;
    logic rd_link;
    logic rs1_link;
    logic ras_push;
    logic ras_pop;

    assign rd_link  = (rd_i == rv_isa_pkg::link_reg_ra) || (rd_i == rv_isa_pkg::link_reg_t0);
    assign rs1_link = (rs1_i == rv_isa_pkg::link_reg_ra) || (rs1_i == rv_isa_pkg::link_reg_t0);

    assign ras_hit_o    = is_jalr_i && rs1_link && !rd_link && (ras_count_q != '0);
    assign ras_target_o = ras_q[ras_top_q];

    assign ras_push = advance_i && (is_jal_i || is_jalr_i) && rd_link;
    assign ras_pop  = advance_i && ras_hit_o;

    // entries carry no reset, the count marks them valid
    always_ff @(posedge clk) begin
        if (ras_push) begin
            ras_q[ras_top_q + 1'b1] <= link_addr_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ras_top_q   <= '0;
            ras_count_q <= '0;
        end else if (ras_push) begin
            ras_top_q <= ras_top_q + 1'b1;
            // full stack wraps over the oldest entry
            if (!ras_count_q[$bits(fetch_pkg::ras_ptr_t)]) begin
                ras_count_q <= ras_count_q + 1'b1;
            end
        end else if (ras_pop) begin
            ras_top_q   <= ras_top_q - 1'b1;
            ras_count_q <= ras_count_q - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/fetch_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_decode (
    input  rv_isa_pkg::xlen_t    instr_i,
    output logic                 is_jal_o,
    output logic                 is_jalr_o,
    output logic                 is_branch_o,
    output logic [2:0]           funct3_o,
    output rv_isa_pkg::reg_idx_t rs1_o,
    output rv_isa_pkg::reg_idx_t rs2_o,
    output rv_isa_pkg::reg_idx_t rd_o,
    output rv_isa_pkg::xlen_t    imm_o
);

    logic [6:0]        opcode;
    rv_isa_pkg::xlen_t imm_j;
    rv_isa_pkg::xlen_t imm_i;
    rv_isa_pkg::xlen_t imm_b;

    assign opcode = instr_i[6:0];

    assign is_jal_o    = (opcode == rv_isa_pkg::opcode_jal);
    assign is_jalr_o   = (opcode == rv_isa_pkg::opcode_jalr);
    assign is_branch_o = (opcode == rv_isa_pkg::opcode_branch);

    assign funct3_o = instr_i[14:12];
    assign rs1_o    = instr_i[19:15];
    assign rd_o     = instr_i[11:7];

    // only branches read rs2 in fetch
    assign rs2_o = is_branch_o ? instr_i[24:20] : '0;

    ////////////////////////////////////////////////////////////////////
    // immediates
    ////////////////////////////////////////////////////////////////////

    assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};
    assign imm_i = {{21{instr_i[31]}}, instr_i[30:20]};
    assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};

    always_comb begin
        if (is_jal_o) begin
            imm_o = imm_j;
        end else if (is_jalr_o) begin
            imm_o = imm_i;
        end else if (is_branch_o) begin
            imm_o = imm_b;
        end else begin
            imm_o = '0;
        end
    end

endmodule

`default_nettype wire

/* design/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    localparam rv_isa_pkg::xlen_t reset_pc = 32'h0000_0000;

    // branch history table, indexed by pc[5:2]
    localparam int unsigned bht_entries = 16;
    typedef logic [3:0] bht_idx_t;

    // return address stack
    localparam int unsigned ras_depth = 4;
    typedef logic [1:0] ras_ptr_t;

    // operand source select
    typedef enum logic [1:0] {
        from_regfile = 2'd0,
        from_mem     = 2'd1,
        from_wb      = 2'd2
    } fwd_sel_t;

endpackage

`default_nettype wire

/* design/fetch_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
    input  logic                 clk,
    input  logic                 rst_n_i,
    output rv_isa_pkg::xlen_t    imem_addr_o,
    input  rv_isa_pkg::xlen_t    imem_data_i,
    output rv_isa_pkg::reg_idx_t rs1_addr_o,
    output rv_isa_pkg::reg_idx_t rs2_addr_o,
    input  rv_isa_pkg::xlen_t    rs1_data_i,
    input  rv_isa_pkg::xlen_t    rs2_data_i,
    input  rv_isa_pkg::reg_idx_t ex_rd_i,
    input  logic                 ex_reg_write_i,
    input  rv_isa_pkg::reg_idx_t mem_rd_i,
    input  logic                 mem_reg_write_i,
    input  logic                 mem_mem_read_i,
    input  rv_isa_pkg::xlen_t    mem_result_i,
    input  rv_isa_pkg::reg_idx_t wb_rd_i,
    input  logic                 wb_reg_write_i,
    input  rv_isa_pkg::xlen_t    wb_result_i,
    input  logic                 flush_i,
    input  rv_isa_pkg::xlen_t    flush_pc_i,
    input  logic                 resolve_valid_i,
    input  rv_isa_pkg::xlen_t    resolve_pc_i,
    input  logic                 resolve_taken_i,
    output rv_isa_pkg::xlen_t    instr_o,
    output rv_isa_pkg::xlen_t    pc_o,
    output logic                 branch_taken_o,
    output logic                 predicted_o,
    output logic                 instr_valid_o,
    input  logic                 instr_ready_i
);

    logic                 is_jal;
    logic                 is_jalr;
    logic                 is_branch;
    logic [2:0]           funct3;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::xlen_t    imm;
    rv_isa_pkg::xlen_t    rs1_value;
    rv_isa_pkg::xlen_t    pc_plus4;
    rv_isa_pkg::xlen_t    ras_target;
    logic                 cmp_taken;
    logic                 rs1_pending;
    logic                 need_predict;
    logic                 bht_taken;
    logic                 ras_hit;
    logic                 stall;
    logic                 advance;
    logic                 running_q;

    // first fetch one cycle after reset release
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            running_q <= 1'b0;
        end else begin
            running_q <= 1'b1;
        end
    end

    // jalr waits for rs1 unless the stack supplies the target
    assign stall         = is_jalr && rs1_pending && !ras_hit;
    assign instr_valid_o = running_q && !flush_i && !stall;
    assign advance       = instr_valid_o && instr_ready_i;

    assign imem_addr_o    = pc_o;
    assign instr_o        = instr_valid_o ? imem_data_i : rv_isa_pkg::nop_instr;
    assign predicted_o    = need_predict;
    assign branch_taken_o = is_branch && (need_predict ? bht_taken : cmp_taken);

    ////////////////////////////////////////////////////////////////////

    fetch_decode u_decode (
        .instr_i     (imem_data_i),
        .is_jal_o    (is_jal),
        .is_jalr_o   (is_jalr),
        .is_branch_o (is_branch),
        .funct3_o    (funct3),
        .rs1_o       (rs1_addr_o),
        .rs2_o       (rs2_addr_o),
        .rd_o        (rd),
        .imm_o       (imm)
    );

    operand_bypass u_bypass (
        .rs1_i           (rs1_addr_o),
        .rs2_i           (rs2_addr_o),
        .rs1_data_i      (rs1_data_i),
        .rs2_data_i      (rs2_data_i),
        .is_branch_i     (is_branch),
        .is_jalr_i       (is_jalr),
        .funct3_i        (funct3),
        .ex_rd_i         (ex_rd_i),
        .ex_reg_write_i  (ex_reg_write_i),
        .mem_rd_i        (mem_rd_i),
        .mem_reg_write_i (mem_reg_write_i),
        .mem_mem_read_i  (mem_mem_read_i),
        .mem_result_i    (mem_result_i),
        .wb_rd_i         (wb_rd_i),
        .wb_reg_write_i  (wb_reg_write_i),
        .wb_result_i     (wb_result_i),
        .rs1_value_o     (rs1_value),
        .cmp_taken_o     (cmp_taken),
        .rs1_pending_o   (rs1_pending),
        .need_predict_o  (need_predict)
    );

    branch_predictor u_predictor (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .pc_i            (pc_o),
        .advance_i       (advance),
        .is_branch_i     (is_branch),
        .is_jal_i        (is_jal),
        .is_jalr_i       (is_jalr),
        .rs1_i           (rs1_addr_o),
        .rd_i            (rd),
        .link_addr_i     (pc_plus4),
        .resolve_valid_i (resolve_valid_i),
        .resolve_pc_i    (resolve_pc_i),
        .resolve_taken_i (resolve_taken_i),
        .bht_taken_o     (bht_taken),
        .ras_hit_o       (ras_hit),
        .ras_target_o    (ras_target)
    );

    pc_unit u_pc (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .advance_i     (advance),
        .flush_i       (flush_i),
        .flush_pc_i    (flush_pc_i),
        .imm_i         (imm),
        .rs1_value_i   (rs1_value),
        .ras_target_i  (ras_target),
        .take_jal_i    (is_jal),
        .take_jalr_i   (is_jalr),
        .use_ras_i     (ras_hit),
        .take_branch_i (branch_taken_o),
        .pc_o          (pc_o),
        .pc_plus4_o    (pc_plus4)
    );

endmodule

`default_nettype wire

/* design/operand_bypass.sv */
`timescale 1ns/1ns
`default_nettype none

module operand_bypass (
    input  rv_isa_pkg::reg_idx_t rs1_i,
    input  rv_isa_pkg::reg_idx_t rs2_i,
    input  rv_isa_pkg::xlen_t    rs1_data_i,
    input  rv_isa_pkg::xlen_t    rs2_data_i,
    input  logic                 is_branch_i,
    input  logic                 is_jalr_i,
    input  logic [2:0]           funct3_i,
    input  rv_isa_pkg::reg_idx_t ex_rd_i,
    input  logic                 ex_reg_write_i,
    input  rv_isa_pkg::reg_idx_t mem_rd_i,
    input  logic                 mem_reg_write_i,
    input  logic                 mem_mem_read_i,
    input  rv_isa_pkg::xlen_t    mem_result_i,
    input  rv_isa_pkg::reg_idx_t wb_rd_i,
    input  logic                 wb_reg_write_i,
    input  rv_isa_pkg::xlen_t    wb_result_i,
    output rv_isa_pkg::xlen_t    rs1_value_o,
    output logic                 cmp_taken_o,
    output logic                 rs1_pending_o,
    output logic                 need_predict_o
);

    fetch_pkg::fwd_sel_t rs1_sel;
    fetch_pkg::fwd_sel_t rs2_sel;
    rv_isa_pkg::xlen_t   rs2_value;
    logic                rs1_busy;
    logic                rs2_busy;

    // mem stage is newer than writeback
    function automatic fetch_pkg::fwd_sel_t fwd_select(
        input rv_isa_pkg::reg_idx_t rs,
        input rv_isa_pkg::reg_idx_t mem_rd,
        input logic                 mem_we,
        input rv_isa_pkg::reg_idx_t wb_rd,
        input logic                 wb_we
    );
        fetch_pkg::fwd_sel_t sel;
        sel = fetch_pkg::from_regfile;
        if (rs != '0 && mem_we && mem_rd == rs) begin
            sel = fetch_pkg::from_mem;
        end else if (rs != '0 && wb_we && wb_rd == rs) begin
            sel = fetch_pkg::from_wb;
        end
        return sel;
    endfunction

    function automatic rv_isa_pkg::xlen_t fwd_value(
        input fetch_pkg::fwd_sel_t sel,
        input rv_isa_pkg::xlen_t   rf_data,
        input rv_isa_pkg::xlen_t   mem_data,
        input rv_isa_pkg::xlen_t   wb_data
    );
        case (sel)
            fetch_pkg::from_mem: return mem_data;
            fetch_pkg::from_wb:  return wb_data;
            default:             return rf_data;
        endcase
    endfunction

    assign rs1_sel = fwd_select(rs1_i, mem_rd_i, mem_reg_write_i, wb_rd_i, wb_reg_write_i);
    assign rs2_sel = fwd_select(rs2_i, mem_rd_i, mem_reg_write_i, wb_rd_i, wb_reg_write_i);

    assign rs1_value_o = fwd_value(rs1_sel, rs1_data_i, mem_result_i, wb_result_i);
    assign rs2_value   = fwd_value(rs2_sel, rs2_data_i, mem_result_i, wb_result_i);

    ////////////////////////////////////////////////////////////////////
    // hazards: result still in execute, or a load in mem
    ////////////////////////////////////////////////////////////////////

    assign rs1_busy = (rs1_i != '0) &&
                      ((ex_reg_write_i && ex_rd_i == rs1_i) ||
                       (mem_mem_read_i && mem_rd_i == rs1_i));
    assign rs2_busy = (rs2_i != '0) &&
                      ((ex_reg_write_i && ex_rd_i == rs2_i) ||
                       (mem_mem_read_i && mem_rd_i == rs2_i));

    assign rs1_pending_o  = (is_branch_i || is_jalr_i) && rs1_busy;
    assign need_predict_o = is_branch_i && (rs1_busy || rs2_busy);

    always_comb begin
        case (funct3_i)
            rv_isa_pkg::funct3_beq:  cmp_taken_o = (rs1_value_o == rs2_value);
            rv_isa_pkg::funct3_bne:  cmp_taken_o = (rs1_value_o != rs2_value);
            rv_isa_pkg::funct3_blt:  cmp_taken_o = ($signed(rs1_value_o) < $signed(rs2_value));
            rv_isa_pkg::funct3_bge:  cmp_taken_o = ($signed(rs1_value_o) >= $signed(rs2_value));
            rv_isa_pkg::funct3_bltu: cmp_taken_o = (rs1_value_o < rs2_value);
            rv_isa_pkg::funct3_bgeu: cmp_taken_o = (rs1_value_o >= rs2_value);
            default:                 cmp_taken_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* design/pc_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module pc_unit (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              advance_i,
    input  logic              flush_i,
    input  rv_isa_pkg::xlen_t flush_pc_i,
    input  rv_isa_pkg::xlen_t imm_i,
    input  rv_isa_pkg::xlen_t rs1_value_i,
    input  rv_isa_pkg::xlen_t ras_target_i,
    input  logic              take_jal_i,
    input  logic              take_jalr_i,
    input  logic              use_ras_i,
    input  logic              take_branch_i,
    output rv_isa_pkg::xlen_t pc_o,
    output rv_isa_pkg::xlen_t pc_plus4_o
);

    rv_isa_pkg::xlen_t pc_q;
    rv_isa_pkg::xlen_t pc_plus_imm;
    rv_isa_pkg::xlen_t jalr_target;
    rv_isa_pkg::xlen_t pc_next;

    assign pc_plus4_o  = pc_q + 32'd4;
    assign pc_plus_imm = pc_q + imm_i;
    assign jalr_target = use_ras_i ? ras_target_i : ((rs1_value_i + imm_i) & ~32'd1);

    // flush first, then jal, jalr, taken branch
    always_comb begin
        if (flush_i) begin
            pc_next = flush_pc_i;
        end else if (take_jal_i) begin
            pc_next = pc_plus_imm;
        end else if (take_jalr_i) begin
            pc_next = jalr_target;
        end else if (take_branch_i) begin
            pc_next = pc_plus_imm;
        end else begin
            pc_next = pc_plus4_o;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= fetch_pkg::reset_pc;
        end else if (flush_i || advance_i) begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

/* design/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;

    ////////////////////////////////////////////////////////////////////
    // opcodes of the control-flow instructions
    ////////////////////////////////////////////////////////////////////

    localparam logic [6:0] opcode_jal    = 7'b1101111;
    localparam logic [6:0] opcode_jalr   = 7'b1100111;
    localparam logic [6:0] opcode_branch = 7'b1100011;

    // branch funct3 codes
    localparam logic [2:0] funct3_beq  = 3'b000;
    localparam logic [2:0] funct3_bne  = 3'b001;
    localparam logic [2:0] funct3_blt  = 3'b100;
    localparam logic [2:0] funct3_bge  = 3'b101;
    localparam logic [2:0] funct3_bltu = 3'b110;
    localparam logic [2:0] funct3_bgeu = 3'b111;

    // addi x0,x0,0
    localparam xlen_t nop_instr = 32'h0000_0013;

    // link registers for call and return hints
    localparam reg_idx_t link_reg_ra = 5'd1;
    localparam reg_idx_t link_reg_t0 = 5'd5;

endpackage

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    --top-module fetch_stage_tb \
    -f sources.f \
    -o fetch_stage_sim

./obj_dir/fetch_stage_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test completed successfully" sim.log; then
    exit 0
fi
exit 1

/* sources.f */
design/rv_isa_pkg.sv
design/fetch_pkg.sv
design/fetch_decode.sv
design/operand_bypass.sv
design/branch_predictor.sv
design/pc_unit.sv
design/fetch_stage.sv
verification/fetch_stage_assertions.sv
verification/fetch_stage_tb.sv

/* verification/fetch_stage_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_stage_assertions (
    input wire logic              clk,
    input wire logic              rst_n_i,
    input wire logic              flush_i,
    input wire logic              instr_valid_o,
    input wire logic              instr_ready_i,
    input wire rv_isa_pkg::xlen_t instr_o,
    input wire rv_isa_pkg::xlen_t pc_o,
    input wire logic              branch_taken_o,
    input wire logic              predicted_o
);

    // nothing offered to decode while in reset
    valid_low_in_reset: assert property (
        @(posedge clk) !rst_n_i |-> !instr_valid_o
    ) else $error("instr_valid_o high during reset");

    // held transfer keeps its payload unless a flush redirects
    stable_while_held: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (instr_valid_o && !instr_ready_i) |=>
            (flush_i || (instr_valid_o && $stable(instr_o) && $stable(pc_o) &&
                         $stable(branch_taken_o) && $stable(predicted_o)))
    ) else $error("outputs changed while held by instr_ready_i");

    nop_when_invalid: assert property (
        @(posedge clk) !instr_valid_o |-> (instr_o == rv_isa_pkg::nop_instr)
    ) else $error("instr_o is not a nop while instr_valid_o is low");

endmodule

`default_nettype wire

/* verification/fetch_stage_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_stage_tb;

    localparam int max_cycles = 4000;

    logic clk;
    logic rst_n_i;
    rv_isa_pkg::xlen_t    imem_addr_o;
    rv_isa_pkg::xlen_t    imem_data_i;
    rv_isa_pkg::reg_idx_t rs1_addr_o;
    rv_isa_pkg::reg_idx_t rs2_addr_o;
    rv_isa_pkg::xlen_t    rs1_data_i;
    rv_isa_pkg::xlen_t    rs2_data_i;
    rv_isa_pkg::reg_idx_t ex_rd_i;
    logic                 ex_reg_write_i;
    rv_isa_pkg::reg_idx_t mem_rd_i;
    logic                 mem_reg_write_i;
    logic                 mem_mem_read_i;
    rv_isa_pkg::xlen_t    mem_result_i;
    rv_isa_pkg::reg_idx_t wb_rd_i;
    logic                 wb_reg_write_i;
    rv_isa_pkg::xlen_t    wb_result_i;
    logic                 flush_i;
    rv_isa_pkg::xlen_t    flush_pc_i;
    logic                 resolve_valid_i;
    rv_isa_pkg::xlen_t    resolve_pc_i;
    logic                 resolve_taken_i;
    rv_isa_pkg::xlen_t    instr_o;
    rv_isa_pkg::xlen_t    pc_o;
    logic                 branch_taken_o;
    logic                 predicted_o;
    logic                 instr_valid_o;
    logic                 instr_ready_i;

    rv_isa_pkg::xlen_t imem [256];
    rv_isa_pkg::xlen_t regs [32];
    rv_isa_pkg::xlen_t ras_model [4];
    logic [1:0]        bht_model [16];
    logic [1:0]        ras_top;
    logic [2:0]        ras_count;
    rv_isa_pkg::xlen_t exp_pc;
    integer            seed;
    int                cycles;
    int                errors;
    logic              checking;
    logic              ready_next;

    fetch_stage dut (.*);

    bind fetch_stage fetch_stage_assertions u_assertions (
        .clk(clk), .rst_n_i(rst_n_i), .flush_i(flush_i),
        .instr_valid_o(instr_valid_o), .instr_ready_i(instr_ready_i),
        .instr_o(instr_o), .pc_o(pc_o),
        .branch_taken_o(branch_taken_o), .predicted_o(predicted_o)
    );

    assign imem_data_i = imem[imem_addr_o[9:2]];
    assign rs1_data_i  = regs[rs1_addr_o];
    assign rs2_data_i  = regs[rs2_addr_o];

    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////////////
    // reporting
    ////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_addr(input rv_isa_pkg::xlen_t got, input rv_isa_pkg::xlen_t exp,
                              input string what);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_reg(input rv_isa_pkg::reg_idx_t got, input rv_isa_pkg::reg_idx_t exp,
                             input string what);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: tests did not finish within %0d cycles", max_cycles);
            abort_run();
        end
    end

    // ready drawn on the falling edge
    always @(negedge clk) begin
        if (rst_n_i) begin
            ready_next = ($random(seed) & 3) != 0;
        end
    end

    always @(posedge clk) begin
        instr_ready_i <= ready_next;
    end

    ////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////

    function automatic logic is_link(input rv_isa_pkg::reg_idx_t r);
        return r == 5'd1 || r == 5'd5;
    endfunction

    function automatic logic pending(input rv_isa_pkg::reg_idx_t r);
        return r != 5'd0 && ((ex_reg_write_i && ex_rd_i == r) ||
                             (mem_mem_read_i && mem_rd_i == r));
    endfunction

    function automatic rv_isa_pkg::xlen_t operand(input rv_isa_pkg::reg_idx_t r);
        if (r != 5'd0 && mem_reg_write_i && mem_rd_i == r) begin
            return mem_result_i;
        end else if (r != 5'd0 && wb_reg_write_i && wb_rd_i == r) begin
            return wb_result_i;
        end
        return regs[r];
    endfunction

    function automatic logic branch_cmp(input logic [2:0] f3, input rv_isa_pkg::xlen_t a,
                                        input rv_isa_pkg::xlen_t b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            3'b111: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic rv_isa_pkg::xlen_t next_pc_ref(
        input rv_isa_pkg::xlen_t pc, input rv_isa_pkg::xlen_t w, input logic taken,
        input logic hit, input rv_isa_pkg::xlen_t ras_tgt, input rv_isa_pkg::xlen_t rs1v
    );
        rv_isa_pkg::xlen_t imm_j;
        rv_isa_pkg::xlen_t imm_i;
        rv_isa_pkg::xlen_t imm_b;
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        imm_i = {{21{w[31]}}, w[30:20]};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        if (w[6:0] == 7'b1101111) begin
            return pc + imm_j;
        end else if (w[6:0] == 7'b1100111) begin
            return hit ? ras_tgt : ((rs1v + imm_i) & ~32'd1);
        end else if (w[6:0] == 7'b1100011 && taken) begin
            return pc + imm_b;
        end
        return pc + 32'd4;
    endfunction

    // checks every fetch cycle and tracks the expected pc
    always @(negedge clk) begin : compare
        rv_isa_pkg::xlen_t    w;
        rv_isa_pkg::reg_idx_t rs1;
        rv_isa_pkg::reg_idx_t rs2;
        rv_isa_pkg::reg_idx_t rd;
        logic jal;
        logic jalr;
        logic br;
        logic hit;
        logic exp_valid;
        logic pred;
        logic taken;
        if (checking) begin
            w    = imem[exp_pc[9:2]];
            jal  = w[6:0] == 7'b1101111;
            jalr = w[6:0] == 7'b1100111;
            br   = w[6:0] == 7'b1100011;
            rs1  = w[19:15];
            rs2  = br ? w[24:20] : 5'd0;
            rd   = w[11:7];
            hit  = jalr && is_link(rs1) && !is_link(rd) && ras_count != 3'd0;
            pred = br && (pending(rs1) || pending(rs2));
            taken = br && (pred ? bht_model[exp_pc[5:2]][1]
                                : branch_cmp(w[14:12], operand(rs1), operand(rs2)));
            exp_valid = !flush_i && !(jalr && pending(rs1) && !hit);
            check_flag(instr_valid_o, exp_valid, "instr_valid_o");
            check_addr(imem_addr_o, exp_pc, "imem_addr_o");
            check_reg(rs1_addr_o, rs1, "rs1_addr_o");
            check_reg(rs2_addr_o, rs2, "rs2_addr_o");
            if (flush_i) begin
                exp_pc = flush_pc_i;
            end else if (exp_valid) begin
                check_addr(pc_o, exp_pc, "pc_o");
                check_addr(instr_o, w, "instr_o");
                check_flag(predicted_o, pred, "predicted_o");
                check_flag(branch_taken_o, taken, "branch_taken_o");
                if (instr_ready_i) begin
                    if ((jal || jalr) && is_link(rd)) begin
                        ras_top = ras_top + 2'd1;
                        ras_model[ras_top] = exp_pc + 32'd4;
                        if (ras_count < 3'd4) begin
                            ras_count = ras_count + 3'd1;
                        end
                        exp_pc = next_pc_ref(exp_pc, w, taken, hit, ras_model[ras_top - 2'd1],
                                             operand(rs1));
                    end else begin
                        exp_pc = next_pc_ref(exp_pc, w, taken, hit, ras_model[ras_top],
                                             operand(rs1));
                        if (hit) begin
                            ras_top   = ras_top - 2'd1;
                            ras_count = ras_count - 3'd1;
                        end
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////////////

    function automatic rv_isa_pkg::xlen_t enc_branch(input logic [2:0] f3,
        input rv_isa_pkg::reg_idx_t a, input rv_isa_pkg::reg_idx_t b, input logic [12:0] off);
        return {off[12], off[10:5], b, a, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic rv_isa_pkg::xlen_t enc_jal(input rv_isa_pkg::reg_idx_t rd,
                                                  input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic rv_isa_pkg::xlen_t enc_jalr(input rv_isa_pkg::reg_idx_t rd,
        input rv_isa_pkg::reg_idx_t rs1, input logic [11:0] off);
        return {off, rs1, 3'b000, rd, 7'b1100111};
    endfunction

    task automatic redirect(input rv_isa_pkg::xlen_t target);
        @(posedge clk);
        flush_i    <= 1'b1;
        flush_pc_i <= target;
        @(posedge clk);
        flush_i <= 1'b0;
    endtask

    task automatic wait_xfer(input rv_isa_pkg::xlen_t addr);
        logic done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = instr_valid_o && instr_ready_i && pc_o == addr;
        end
        @(posedge clk);
    endtask

    task automatic train(input rv_isa_pkg::xlen_t pc, input logic taken);
        @(posedge clk);
        resolve_valid_i <= 1'b1;
        resolve_pc_i    <= pc;
        resolve_taken_i <= taken;
        @(posedge clk);
        resolve_valid_i <= 1'b0;
        if (taken && bht_model[pc[5:2]] != 2'd3) begin
            bht_model[pc[5:2]] += 2'd1;
        end
        if (!taken && bht_model[pc[5:2]] != 2'd0) begin
            bht_model[pc[5:2]] -= 2'd1;
        end
    endtask

    task automatic branch_case(input logic [2:0] f3);
        rv_isa_pkg::xlen_t a;
        rv_isa_pkg::xlen_t b;
        a = $random(seed);
        b = (($random(seed) & 3) == 0) ? a : $random(seed);
        @(posedge clk);
        regs[10] <= a;
        regs[11] <= b;
        mem_result_i <= (($random(seed) & 1) != 0) ? b : $random(seed);
        wb_result_i  <= $random(seed);
        imem[64] <= enc_branch(f3, 5'd10, 5'd11, 13'h20);
        redirect(32'h100);
        wait_xfer(32'h100);
    endtask

    ////////////////////////////////////////////////////////////////////

    initial begin
        logic [2:0] kinds [6];
        kinds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        seed = 32'h906e;
        clk = 1'b0;
        rst_n_i = 1'b0;
        ex_rd_i = '0;
        ex_reg_write_i = 1'b0;
        mem_rd_i = '0;
        mem_reg_write_i = 1'b0;
        mem_mem_read_i = 1'b0;
        mem_result_i = '0;
        wb_rd_i = '0;
        wb_reg_write_i = 1'b0;
        wb_result_i = '0;
        flush_i = 1'b0;
        flush_pc_i = '0;
        resolve_valid_i = 1'b0;
        resolve_pc_i = '0;
        resolve_taken_i = 1'b0;
        instr_ready_i = 1'b0;
        ready_next = 1'b1;
        cycles = 0;
        errors = 0;
        checking = 1'b0;
        exp_pc = fetch_pkg::reset_pc;
        ras_top = '0;
        ras_count = '0;
        // addi x0,x0,index so every word differs
        for (int i = 0; i < 256; i++) begin
            imem[i] = {4'd0, i[7:0], 20'h00013};
        end
        for (int i = 0; i < 32; i++) begin
            regs[i] = {i[7:0], 24'h5a5a00} + 32'(i);
        end
        regs[0] = '0;
        for (int i = 0; i < 16; i++) begin
            bht_model[i] = 2'd1;
        end

        repeat (8) @(posedge clk);
        rst_n_i <= 1'b1;
        @(posedge clk);
        checking = 1'b1;

        // straight-line code under random ready
        wait_xfer(32'h40);

        // plain comparisons then mem and wb forwarding
        foreach (kinds[k]) begin
            repeat (4) branch_case(kinds[k]);
        end
        foreach (kinds[k]) begin
            @(posedge clk);
            mem_rd_i        <= (($random(seed) & 1) != 0) ? 5'd10 : 5'd11;
            mem_reg_write_i <= 1'b1;
            wb_rd_i         <= (($random(seed) & 1) != 0) ? 5'd10 : 5'd11;
            wb_reg_write_i  <= 1'b1;
            repeat (3) branch_case(kinds[k]);
        end
        @(posedge clk);
        mem_reg_write_i <= 1'b0;
        wb_reg_write_i  <= 1'b0;

        // operand in execute so the trained counter decides
        train(32'h100, 1'b1);
        train(32'h100, 1'b1);
        @(posedge clk);
        ex_rd_i        <= 5'd11;
        ex_reg_write_i <= 1'b1;
        branch_case(3'b000);
        repeat (3) train(32'h100, 1'b0);
        branch_case(3'b001);
        @(posedge clk);
        ex_reg_write_i <= 1'b0;

        // call and return through the stack then a stalled jalr
        @(posedge clk);
        imem[128] <= enc_jal(5'd1, 21'h40);
        imem[144] <= enc_jalr(5'd0, 5'd1, 12'h0);
        imem[129] <= enc_jalr(5'd0, 5'd6, 12'h0);
        regs[6]   <= 32'h300;
        ex_rd_i        <= 5'd6;
        ex_reg_write_i <= 1'b1;
        redirect(32'h200);
        wait_xfer(32'h240);
        while (pc_o != 32'h204) @(negedge clk);
        repeat (6) @(posedge clk);
        ex_reg_write_i <= 1'b0;
        wait_xfer(32'h300);

        // flush in the middle of straight-line code
        redirect(32'h380);
        wait_xfer(32'h384);

        repeat (4) @(posedge clk);
        if (errors == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

`default_nettype wire
